/* design/pmp_params.svh */
`ifndef PMP_PARAMS_SVH
`define PMP_PARAMS_SVH

// Number of implemented regions, one pmpcfg0 register holds them all
`define PMP_NUM_REGIONS 4

// CSR addresses
`define CSR_PMPCFG0  12'h3A0
`define CSR_PMPADDR0 12'h3B0
`define CSR_MSECCFG  12'h747

// Exception causes
`define EXC_INSTR_ACC_FAULT 6'd1
`define EXC_ILL_INSTR       6'd2
`define EXC_LOAD_ACC_FAULT  6'd5
`define EXC_STORE_ACC_FAULT 6'd7

// Rule-locking bypass position in mseccfg
`define MSECCFG_RLB_BIT 2

// Field positions inside one cfg byte
`define PMP_CFG_LOCK_BIT 7
`define PMP_CFG_MODE_LSB 3
`define PMP_CFG_X_BIT    2
`define PMP_CFG_W_BIT    1
`define PMP_CFG_R_BIT    0

// Bits 6:5 are reserved and read as zero
`define PMP_CFG_RSVD_MASK (8'h60)

`endif

/* design/pmp_pkg.sv */
`include "pmp_params.svh"

package pmp_pkg;

  // Data word, used for CSR data and byte addresses
  typedef logic [31:0] xlen_t;

  typedef logic [11:0] csr_addr_t;

  typedef logic [5:0] cause_t;

  // Lock, two reserved bits, mode, then X W R from the top
  typedef logic [7:0] pmp_cfg_t;

  // One flag per region
  typedef logic [`PMP_NUM_REGIONS-1:0] region_mask_t;

  // Byte count minus one
  typedef logic [1:0] acc_size_t;

  // Address matching mode of a region
  typedef enum logic [1:0] {
    PMP_MODE_OFF   = 2'd0,
    PMP_MODE_TOR   = 2'd1,
    PMP_MODE_NA4   = 2'd2,
    PMP_MODE_NAPOT = 2'd3
  } pmp_mode_e;

  typedef enum logic [1:0] {
    PRIV_U = 2'd0,
    PRIV_M = 2'd3
  } priv_e;

  typedef enum logic [1:0] {
    ACC_EXEC  = 2'd0,
    ACC_READ  = 2'd1,
    ACC_WRITE = 2'd2
  } access_e;

endpackage

/* design/pmp_csr_if.sv */
`timescale 1ns/1ps
`include "pmp_params.svh"

// Live PMP register contents, no handshake
interface pmp_csr_if;

  pmp_pkg::pmp_cfg_t [`PMP_NUM_REGIONS-1:0] cfg;

  // Word addresses, byte address shifted right by two
  pmp_pkg::xlen_t [`PMP_NUM_REGIONS-1:0] addr;

  logic rlb;

  modport regs (
    output cfg,
    output addr,
    output rlb
  );

  modport check (
    input cfg,
    input addr,
    input rlb
  );

endinterface

/* design/pmp_cfg_legalize.sv */
`timescale 1ns/1ps
`include "pmp_params.svh"

module pmp_cfg_legalize (
  input  pmp_pkg::pmp_cfg_t cfg_old_i,
  input  pmp_pkg::pmp_cfg_t cfg_new_i,
  input  logic              rlb_i,
  output pmp_pkg::pmp_cfg_t cfg_o
);

  logic locked;
  logic rw_reserved;

  // Lock holds unless the bypass is on
  assign locked = cfg_old_i[`PMP_CFG_LOCK_BIT] && !rlb_i;

  // W without R is reserved
  assign rw_reserved = cfg_new_i[`PMP_CFG_W_BIT] && !cfg_new_i[`PMP_CFG_R_BIT];

  always_comb begin
    cfg_o = cfg_new_i;

    // Keep the old permissions, mode and lock still follow the attempt
    if (rw_reserved) begin
      cfg_o[`PMP_CFG_X_BIT:`PMP_CFG_R_BIT] = cfg_old_i[`PMP_CFG_X_BIT:`PMP_CFG_R_BIT];
    end

    if (locked) begin
      cfg_o = cfg_old_i;
    end

    cfg_o = cfg_o & ~`PMP_CFG_RSVD_MASK;
  end

  // Stored bytes never carry reserved bits
  always_comb begin
    a_rsvd_zero: assert ((cfg_old_i & `PMP_CFG_RSVD_MASK) == '0);
  end

endmodule

/* design/pmp_csr_regs.sv */
`timescale 1ns/1ps
`include "pmp_params.svh"

module pmp_csr_regs (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               csr_req_valid_i,
  output logic               csr_req_ready_o,
  input  pmp_pkg::csr_addr_t csr_addr_i,
  input  pmp_pkg::xlen_t     csr_wdata_i,
  input  pmp_pkg::priv_e     csr_priv_i,
  output logic               csr_rsp_valid_o,
  input  logic               csr_rsp_ready_i,
  output pmp_pkg::xlen_t     csr_rdata_o,
  output logic               csr_illegal_o,
  pmp_csr_if.regs            csr
);

  localparam int N = `PMP_NUM_REGIONS;

  pmp_pkg::csr_addr_t        addr_off;
  logic                      sel_cfg;
  logic                      sel_addr;
  logic                      sel_msec;
  logic                      illegal;
  logic                      req_fire;
  logic                      wr_en;
  pmp_pkg::region_mask_t     lock_vec;
  pmp_pkg::region_mask_t     addr_locked;
  pmp_pkg::pmp_cfg_t [N-1:0] cfg_legal;
  pmp_pkg::xlen_t            rdata;

  // One response slot
  assign csr_req_ready_o = !csr_rsp_valid_o || csr_rsp_ready_i;
  assign req_fire        = csr_req_valid_i && csr_req_ready_o;

  // Address decode
  assign addr_off = csr_addr_i - `CSR_PMPADDR0;
  assign sel_cfg  = (csr_addr_i == `CSR_PMPCFG0);
  assign sel_addr = (addr_off < pmp_pkg::csr_addr_t'(N));
  assign sel_msec = (csr_addr_i == `CSR_MSECCFG);

  assign illegal = (csr_priv_i != pmp_pkg::PRIV_M) || !(sel_cfg || sel_addr || sel_msec);
  assign wr_en   = req_fire && !illegal;

  for (genvar i = 0; i < N; i++) begin : gen_region
    assign lock_vec[i] = csr.cfg[i][`PMP_CFG_LOCK_BIT];

    // A locked TOR entry above also guards this address
    if (i < N - 1) begin : gen_tor_above
      assign addr_locked[i] = !csr.rlb && (lock_vec[i] || (lock_vec[i+1] &&
        csr.cfg[i+1][`PMP_CFG_MODE_LSB +: 2] == pmp_pkg::PMP_MODE_TOR));
    end else begin : gen_top
      assign addr_locked[i] = !csr.rlb && lock_vec[i];
    end

    pmp_cfg_legalize u_legalize (
      .cfg_old_i (csr.cfg[i]),
      .cfg_new_i (csr_wdata_i[8*i +: 8]),
      .rlb_i     (csr.rlb),
      .cfg_o     (cfg_legal[i])
    );

    a_locked_cfg_stable: assert property (
      @(posedge clk_i) disable iff (!rst_ni)
      csr.cfg[i][`PMP_CFG_LOCK_BIT] && !csr.rlb |=> $stable(csr.cfg[i])
    );
  end

  // Read data is the value before the write
  always_comb begin
    rdata = '0;
    if (sel_cfg) begin
      rdata = pmp_pkg::xlen_t'(csr.cfg);
    end else if (sel_msec) begin
      rdata[`MSECCFG_RLB_BIT] = csr.rlb;
    end else begin
      for (int i = 0; i < N; i++) begin
        if (addr_off == pmp_pkg::csr_addr_t'(i)) begin
          rdata = csr.addr[i];
        end
      end
    end
    if (illegal) begin
      rdata = '0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      csr.cfg  <= '0;
      csr.addr <= '0;
      csr.rlb  <= 1'b0;
    end else if (wr_en) begin
      if (sel_cfg) begin
        csr.cfg <= cfg_legal;
      end
      for (int i = 0; i < N; i++) begin
        if (addr_off == pmp_pkg::csr_addr_t'(i) && !addr_locked[i]) begin
          csr.addr[i] <= csr_wdata_i;
        end
      end
      // RLB can only be raised while nothing is locked
      if (sel_msec && (csr.rlb || lock_vec == '0)) begin
        csr.rlb <= csr_wdata_i[`MSECCFG_RLB_BIT];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      csr_rsp_valid_o <= 1'b0;
    end else if (req_fire) begin
      csr_rsp_valid_o <= 1'b1;
    end else if (csr_rsp_ready_i) begin
      csr_rsp_valid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      csr_rdata_o   <= rdata;
      csr_illegal_o <= illegal;
    end
  end

endmodule

/* design/pmp_region_match.sv */
`timescale 1ns/1ps
`include "pmp_params.svh"

module pmp_region_match (
  input  pmp_pkg::xlen_t   addr_i,
  input  pmp_pkg::access_e type_i,
  input  pmp_pkg::priv_e   priv_i,
  pmp_csr_if.check         csr,
  output logic             allow_o
);

  localparam int N = `PMP_NUM_REGIONS;

  pmp_pkg::xlen_t        word_addr;
  pmp_pkg::region_mask_t match;
  logic                  hit;
  pmp_pkg::pmp_cfg_t     hit_cfg;
  logic                  perm;
  logic                  is_m;

  // G=0 regions are word aligned, so compare word addresses
  assign word_addr = {2'b00, addr_i[31:2]};
  assign is_m      = (priv_i == pmp_pkg::PRIV_M);

  for (genvar i = 0; i < N; i++) begin : gen_match
    pmp_pkg::pmp_mode_e mode;
    pmp_pkg::xlen_t     napot_mask;
    logic               tor_lo_ok;

    assign mode = pmp_pkg::pmp_mode_e'(csr.cfg[i][`PMP_CFG_MODE_LSB +: 2]);

    // k trailing ones leave k+1 low word bits free
    assign napot_mask = ~(csr.addr[i] ^ (csr.addr[i] + 32'd1));

    // Region 0 starts at zero
    if (i == 0) begin : gen_base
      assign tor_lo_ok = 1'b1;
    end else begin : gen_above
      assign tor_lo_ok = (word_addr >= csr.addr[i-1]);
    end

    assign match[i] =
      (mode == pmp_pkg::PMP_MODE_TOR)   ? (tor_lo_ok && (word_addr < csr.addr[i])) :
      (mode == pmp_pkg::PMP_MODE_NA4)   ? (word_addr == csr.addr[i]) :
      (mode == pmp_pkg::PMP_MODE_NAPOT) ? ((word_addr & napot_mask) ==
                                           (csr.addr[i] & napot_mask)) :
      1'b0;
  end

  // Lowest index wins
  always_comb begin
    hit     = 1'b0;
    hit_cfg = '0;
    for (int i = N - 1; i >= 0; i--) begin
      if (match[i]) begin
        hit     = 1'b1;
        hit_cfg = csr.cfg[i];
      end
    end
  end

  always_comb begin
    case (type_i)
      pmp_pkg::ACC_EXEC:  perm = hit_cfg[`PMP_CFG_X_BIT];
      pmp_pkg::ACC_READ:  perm = hit_cfg[`PMP_CFG_R_BIT];
      pmp_pkg::ACC_WRITE: perm = hit_cfg[`PMP_CFG_W_BIT];
      default:            perm = 1'b0;
    endcase
  end

  // M-mode only feels locked regions
  assign allow_o = !hit ? is_m :
                   is_m ? (!hit_cfg[`PMP_CFG_LOCK_BIT] || perm) :
                   perm;

endmodule

/* design/pmp_access_check.sv */
`timescale 1ns/1ps
`include "pmp_params.svh"

module pmp_access_check (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               acc_valid_i,
  output logic               acc_ready_o,
  input  pmp_pkg::xlen_t     acc_addr_i,
  input  pmp_pkg::access_e   acc_type_i,
  input  pmp_pkg::acc_size_t acc_size_i,
  input  pmp_pkg::priv_e     acc_priv_i,
  output logic               chk_valid_o,
  input  logic               chk_ready_i,
  output logic               chk_allow_o,
  output pmp_pkg::cause_t    chk_cause_o,
  pmp_csr_if.check           csr
);

  pmp_pkg::xlen_t  last_addr;
  logic            split;
  logic            allow_first;
  logic            allow_last;
  logic            allow;
  logic            acc_fire;
  pmp_pkg::cause_t cause;

  assign acc_ready_o = !chk_valid_o || chk_ready_i;
  assign acc_fire    = acc_valid_i && acc_ready_o;

  // Last byte touched, may wrap past the top
  assign last_addr = acc_addr_i + pmp_pkg::xlen_t'(acc_size_i);
  assign split     = (last_addr[31:2] != acc_addr_i[31:2]);

  pmp_region_match u_match_first (
    .addr_i  (acc_addr_i),
    .type_i  (acc_type_i),
    .priv_i  (acc_priv_i),
    .csr     (csr),
    .allow_o (allow_first)
  );

  pmp_region_match u_match_last (
    .addr_i  (last_addr),
    .type_i  (acc_type_i),
    .priv_i  (acc_priv_i),
    .csr     (csr),
    .allow_o (allow_last)
  );

  // Both ends must pass on a split access
  assign allow = allow_first && (!split || allow_last);

  always_comb begin
    cause = '0;
    if (!allow) begin
      case (acc_type_i)
        pmp_pkg::ACC_EXEC:  cause = `EXC_INSTR_ACC_FAULT;
        pmp_pkg::ACC_READ:  cause = `EXC_LOAD_ACC_FAULT;
        pmp_pkg::ACC_WRITE: cause = `EXC_STORE_ACC_FAULT;
        default:            cause = '0;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      chk_valid_o <= 1'b0;
    end else if (acc_fire) begin
      chk_valid_o <= 1'b1;
    end else if (chk_ready_i) begin
      chk_valid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (acc_fire) begin
      chk_allow_o <= allow;
      chk_cause_o <= cause;
    end
  end

  a_rsp_stable: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    chk_valid_o && !chk_ready_i
    |=> chk_valid_o && $stable(chk_allow_o) && $stable(chk_cause_o)
  );

endmodule

/* design/pmp_top.sv */
`timescale 1ns/1ps

module pmp_top (
  input  logic               clk_i,
  input  logic               rst_ni,
  // CSR port
  input  logic               csr_req_valid_i,
  output logic               csr_req_ready_o,
  input  pmp_pkg::csr_addr_t csr_addr_i,
  input  pmp_pkg::xlen_t     csr_wdata_i,
  input  pmp_pkg::priv_e     csr_priv_i,
  output logic               csr_rsp_valid_o,
  input  logic               csr_rsp_ready_i,
  output pmp_pkg::xlen_t     csr_rdata_o,
  output logic               csr_illegal_o,
  // Access port
  input  logic               acc_valid_i,
  output logic               acc_ready_o,
  input  pmp_pkg::xlen_t     acc_addr_i,
  input  pmp_pkg::access_e   acc_type_i,
  input  pmp_pkg::acc_size_t acc_size_i,
  input  pmp_pkg::priv_e     acc_priv_i,
  output logic               chk_valid_o,
  input  logic               chk_ready_i,
  output logic               chk_allow_o,
  output pmp_pkg::cause_t    chk_cause_o
);

  pmp_csr_if csr_if ();

  pmp_csr_regs u_csr_regs (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .csr_req_valid_i (csr_req_valid_i),
    .csr_req_ready_o (csr_req_ready_o),
    .csr_addr_i      (csr_addr_i),
    .csr_wdata_i     (csr_wdata_i),
    .csr_priv_i      (csr_priv_i),
    .csr_rsp_valid_o (csr_rsp_valid_o),
    .csr_rsp_ready_i (csr_rsp_ready_i),
    .csr_rdata_o     (csr_rdata_o),
    .csr_illegal_o   (csr_illegal_o),
    .csr             (csr_if.regs)
  );

  pmp_access_check u_access_check (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .acc_valid_i (acc_valid_i),
    .acc_ready_o (acc_ready_o),
    .acc_addr_i  (acc_addr_i),
    .acc_type_i  (acc_type_i),
    .acc_size_i  (acc_size_i),
    .acc_priv_i  (acc_priv_i),
    .chk_valid_o (chk_valid_o),
    .chk_ready_i (chk_ready_i),
    .chk_allow_o (chk_allow_o),
    .chk_cause_o (chk_cause_o),
    .csr         (csr_if.check)
  );

endmodule

/* testbench/pmp_tb_model.svh */
`ifndef PMP_TB_MODEL_SVH
`define PMP_TB_MODEL_SVH

// Register state as the model expects it
logic [7:0]  m_cfg [4];
logic [31:0] m_addr [4];
logic        m_rlb;

function automatic void model_reset();
  for (int i = 0; i < 4; i++) begin
    m_cfg[i] = '0;
    m_addr[i] = '0;
  end
  m_rlb = 1'b0;
endfunction

// Value actually stored for one cfg byte write attempt
function automatic logic [7:0] legal_cfg(input logic [7:0] old_b, input logic [7:0] new_b);
  logic [7:0] b;
  if (old_b[7] && !m_rlb) begin
    return old_b;
  end
  b = new_b;
  if (b[1] && !b[0]) begin
    b[2:0] = old_b[2:0];
  end
  b[6:5] = 2'b00;
  return b;
endfunction

function automatic logic addr_locked(input int i);
  if (m_rlb) begin
    return 1'b0;
  end
  if (m_cfg[i][7]) begin
    return 1'b1;
  end
  // Locked TOR entry above uses this register as its base
  if (i < 3) begin
    return m_cfg[i+1][7] && (m_cfg[i+1][4:3] == 2'd1);
  end
  return 1'b0;
endfunction

// csrrw: old value out, legalized new value in
function automatic void model_csr(input logic [11:0] a, input logic [31:0] wd,
                                  input logic [1:0] priv, output logic [31:0] rd,
                                  output logic ill);
  int   idx;
  logic any_lock;
  idx = int'(a) - int'(`CSR_PMPADDR0);
  ill = (priv != 2'd3) ||
        !(a == `CSR_PMPCFG0 || a == `CSR_MSECCFG || (idx >= 0 && idx < 4));
  rd = '0;
  any_lock = 1'b0;
  for (int i = 0; i < 4; i++) begin
    any_lock = any_lock | m_cfg[i][7];
  end
  if (ill) begin
    return;
  end
  if (a == `CSR_PMPCFG0) begin
    rd = {m_cfg[3], m_cfg[2], m_cfg[1], m_cfg[0]};
    for (int i = 0; i < 4; i++) begin
      m_cfg[i] = legal_cfg(m_cfg[i], wd[8*i +: 8]);
    end
  end else if (a == `CSR_MSECCFG) begin
    rd = {29'd0, m_rlb, 2'd0};
    if (m_rlb || !any_lock) begin
      m_rlb = wd[`MSECCFG_RLB_BIT];
    end
  end else begin
    rd = m_addr[idx];
    if (!addr_locked(idx)) begin
      m_addr[idx] = wd;
    end
  end
endfunction

// Does region i cover word address wa
function automatic logic region_hits(input int i, input logic [31:0] wa);
  logic [31:0] lo;
  int          k;
  case (m_cfg[i][4:3])
    2'd1: begin
      lo = '0;
      if (i > 0) begin
        lo = m_addr[i-1];
      end
      return (wa >= lo) && (wa < m_addr[i]);
    end
    2'd2: return wa == m_addr[i];
    2'd3: begin
      k = 0;
      while (k < 32 && m_addr[i][k]) begin
        k++;
      end
      // 2^(k+3) bytes, that is 2^(k+1) words
      return (k >= 31) || ((wa >> (k + 1)) == (m_addr[i] >> (k + 1)));
    end
    default: return 1'b0;
  endcase
endfunction

function automatic logic byte_allowed(input logic [31:0] ba, input logic [1:0] typ,
                                      input logic [1:0] priv);
  logic [31:0] wa;
  logic        perm;
  wa = {2'b00, ba[31:2]};
  for (int i = 0; i < 4; i++) begin
    if (region_hits(i, wa)) begin
      case (typ)
        2'd0: perm = m_cfg[i][2];
        2'd1: perm = m_cfg[i][0];
        default: perm = m_cfg[i][1];
      endcase
      if (priv == 2'd3) begin
        return !m_cfg[i][7] || perm;
      end
      return perm;
    end
  end
  return priv == 2'd3;
endfunction

// Expected {allow, cause} for one access
function automatic logic [6:0] expect_access(input logic [31:0] addr, input logic [1:0] typ,
                                             input logic [1:0] size, input logic [1:0] priv);
  logic [31:0] last;
  logic        allow;
  logic [5:0]  cause;
  last = addr + {30'd0, size};
  allow = byte_allowed(addr, typ, priv) &&
          (last[31:2] == addr[31:2] || byte_allowed(last, typ, priv));
  cause = 6'd0;
  if (!allow) begin
    cause = (typ == 2'd0) ? `EXC_INSTR_ACC_FAULT :
            (typ == 2'd1) ? `EXC_LOAD_ACC_FAULT : `EXC_STORE_ACC_FAULT;
  end
  return {allow, cause};
endfunction

`endif

/* testbench/pmp_tb.sv */
`timescale 1ns/1ps
`include "pmp_params.svh"

module pmp_tb;

  // About 2k cycles of traffic in total, so this leaves a wide margin
  localparam int CYCLE_LIMIT = 20000;

  logic               clk_i;
  logic               rst_ni;
  logic               csr_req_valid_i;
  logic               csr_req_ready_o;
  pmp_pkg::csr_addr_t csr_addr_i;
  pmp_pkg::xlen_t     csr_wdata_i;
  pmp_pkg::priv_e     csr_priv_i;
  logic               csr_rsp_valid_o;
  logic               csr_rsp_ready_i;
  pmp_pkg::xlen_t     csr_rdata_o;
  logic               csr_illegal_o;
  logic               acc_valid_i;
  logic               acc_ready_o;
  pmp_pkg::xlen_t     acc_addr_i;
  pmp_pkg::access_e   acc_type_i;
  pmp_pkg::acc_size_t acc_size_i;
  pmp_pkg::priv_e     acc_priv_i;
  logic               chk_valid_o;
  logic               chk_ready_i;
  logic               chk_allow_o;
  pmp_pkg::cause_t    chk_cause_o;

  `include "pmp_tb_model.svh"

  logic [31:0] lfsr;
  logic        bp_mode;
  int          errors;
  int          tests;
  int          failed_tests;
  int          test_err_start;
  int          cycles;
  int          csr_acc_cnt;
  int          csr_rsp_cnt;
  int          chk_acc_cnt;
  int          chk_rsp_cnt;
  string       cur_test;
  logic [32:0] csr_q [$];
  logic [6:0]  acc_q [$];
  logic [31:0] last_rdata;

  pmp_top dut_i (
    .clk_i (clk_i), .rst_ni (rst_ni),
    .csr_req_valid_i (csr_req_valid_i), .csr_req_ready_o (csr_req_ready_o),
    .csr_addr_i (csr_addr_i), .csr_wdata_i (csr_wdata_i), .csr_priv_i (csr_priv_i),
    .csr_rsp_valid_o (csr_rsp_valid_o), .csr_rsp_ready_i (csr_rsp_ready_i),
    .csr_rdata_o (csr_rdata_o), .csr_illegal_o (csr_illegal_o),
    .acc_valid_i (acc_valid_i), .acc_ready_o (acc_ready_o), .acc_addr_i (acc_addr_i),
    .acc_type_i (acc_type_i), .acc_size_i (acc_size_i), .acc_priv_i (acc_priv_i),
    .chk_valid_o (chk_valid_o), .chk_ready_i (chk_ready_i),
    .chk_allow_o (chk_allow_o), .chk_cause_o (chk_cause_o)
  );

  always #5 clk_i = ~clk_i;

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      r = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
    if (exp_v !== act_v) begin
      $display("mismatch %s expected %h actual %h", name, exp_v, act_v);
      errors++;
    end
  endtask

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("run timed out after %0d cycles in test %s", cycles, cur_test);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  // Ready inputs move after the stimulus thread
  always @(posedge clk_i) begin
    logic [31:0] r;
    #2;
    r = bp_mode ? rand_bits(2) : 32'd3;
    csr_rsp_ready_i = r[0];
    chk_ready_i = r[1];
  end

  // Response scoreboards
  always @(posedge clk_i) begin
    logic [32:0] ce;
    logic [6:0]  ae;
    if (rst_ni) begin
      if (csr_req_valid_i && csr_req_ready_o) csr_acc_cnt++;
      if (acc_valid_i && acc_ready_o) chk_acc_cnt++;
      if (csr_rsp_valid_o && csr_rsp_ready_i) begin
        csr_rsp_cnt++;
        if (csr_q.size() == 0) begin
          $display("%s: CSR response arrived with none expected", cur_test);
          errors++;
        end else begin
          ce = csr_q.pop_front();
          check_value({cur_test, " rdata"}, ce[31:0], csr_rdata_o);
          check_value({cur_test, " illegal"}, {31'd0, ce[32]}, {31'd0, csr_illegal_o});
          last_rdata = csr_rdata_o;
        end
      end
      if (chk_valid_o && chk_ready_i) begin
        chk_rsp_cnt++;
        if (acc_q.size() == 0) begin
          $display("%s: access response arrived with none expected", cur_test);
          errors++;
        end else begin
          ae = acc_q.pop_front();
          check_value({cur_test, " allow"}, {31'd0, ae[6]}, {31'd0, chk_allow_o});
          check_value({cur_test, " cause"}, {26'd0, ae[5:0]}, {26'd0, chk_cause_o});
        end
      end
      if (csr_acc_cnt - csr_rsp_cnt > 1 || chk_acc_cnt - chk_rsp_cnt > 1) begin
        $display("%s: more than one request outstanding on a port", cur_test);
        errors++;
      end
    end
  end

  task automatic wait_idle();
    do @(posedge clk_i); while (csr_q.size() != 0 || acc_q.size() != 0);
    #1;
  endtask

  task automatic apply_reset();
    wait_idle();
    rst_ni = 1'b0;
    repeat (8) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    model_reset();
    csr_acc_cnt = 0;
    csr_rsp_cnt = 0;
    chk_acc_cnt = 0;
    chk_rsp_cnt = 0;
  endtask

  task automatic csr_op(input logic [11:0] a, input logic [31:0] wd, input logic [1:0] priv);
    logic [31:0] rd;
    logic        ill;
    csr_req_valid_i = 1'b1;
    csr_addr_i = a;
    csr_wdata_i = wd;
    csr_priv_i = pmp_pkg::priv_e'(priv);
    do @(posedge clk_i); while (!csr_req_ready_o);
    model_csr(a, wd, priv, rd, ill);
    csr_q.push_back({ill, rd});
    #1;
    csr_req_valid_i = 1'b0;
  endtask

  task automatic acc_op();
    logic [31:0] r;
    logic [31:0] addr;
    logic [1:0]  t;
    logic [1:0]  s;
    logic [1:0]  p;
    r = rand_bits(3);
    addr = (r == 0) ? rand_bits(32) : rand_bits(14);
    r = rand_bits(2);
    t = (r[1:0] == 2'd3) ? 2'd1 : r[1:0];
    r = rand_bits(2);
    s = (r[1:0] == 2'd2) ? 2'd3 : r[1:0];
    r = rand_bits(1);
    p = r[0] ? 2'd3 : 2'd0;
    acc_valid_i = 1'b1;
    acc_addr_i = addr;
    acc_type_i = pmp_pkg::access_e'(t);
    acc_size_i = s;
    acc_priv_i = pmp_pkg::priv_e'(p);
    do @(posedge clk_i); while (!acc_ready_o);
    acc_q.push_back(expect_access(addr, t, s, p));
    #1;
    acc_valid_i = 1'b0;
  endtask

  function automatic logic [11:0] valid_csr_addr();
    logic [31:0] r;
    r = rand_bits(3);
    if (r[2:0] == 3'd0 || r[2:0] == 3'd6) return `CSR_PMPCFG0;
    if (r[2:0] == 3'd1 || r[2:0] == 3'd7) return `CSR_MSECCFG;
    return `CSR_PMPADDR0 + {9'd0, r[2:0]} - 12'd2;
  endfunction

  task automatic start_test(input string name);
    cur_test = name;
    test_err_start = errors;
    apply_reset();
  endtask

  task automatic end_test();
    wait_idle();
    tests++;
    if (errors == test_err_start) begin
      $display("test %s passed", cur_test);
    end else begin
      failed_tests++;
      $display("test %s failed with %0d errors", cur_test, errors - test_err_start);
    end
  endtask

  initial begin
    logic [31:0] r;
    clk_i = 1'b0;
    rst_ni = 1'b0;
    csr_req_valid_i = 1'b0;
    csr_addr_i = '0;
    csr_wdata_i = '0;
    csr_priv_i = pmp_pkg::PRIV_M;
    csr_rsp_ready_i = 1'b1;
    acc_valid_i = 1'b0;
    acc_addr_i = '0;
    acc_type_i = pmp_pkg::ACC_EXEC;
    acc_size_i = '0;
    acc_priv_i = pmp_pkg::PRIV_M;
    chk_ready_i = 1'b1;
    lfsr = 32'h9b1c0406;
    bp_mode = 1'b0;
    errors = 0;
    tests = 0;
    failed_tests = 0;
    cycles = 0;
    last_rdata = '0;
    model_reset();

    start_test("reset_and_random_writes");
    csr_op(`CSR_PMPCFG0, 32'd0, 2'd3);
    csr_op(`CSR_MSECCFG, 32'd0, 2'd3);
    for (int i = 0; i < 4; i++) begin
      csr_op(`CSR_PMPADDR0 + 12'(i), 32'd0, 2'd3);
    end
    for (int i = 0; i < 100; i++) begin
      csr_op(valid_csr_addr(), rand_bits(32), 2'd3);
    end
    end_test();

    start_test("illegal_access");
    for (int i = 0; i < 6; i++) begin
      csr_op(`CSR_PMPADDR0 + 12'(i % 4), rand_bits(32), 2'd3);
    end
    for (int i = 0; i < 20; i++) begin
      r = rand_bits(5);
      if (r[4]) csr_op(valid_csr_addr(), rand_bits(32), 2'd0);
      else csr_op(12'h3B4 + {8'd0, r[3:0]}, rand_bits(32), 2'd3);
    end
    csr_op(`CSR_PMPCFG0, 32'd0, 2'd3);
    for (int i = 0; i < 4; i++) begin
      csr_op(`CSR_PMPADDR0 + 12'(i), 32'd0, 2'd3);
    end
    end_test();

    start_test("locking");
    csr_op(`CSR_PMPADDR0 + 12'd1, 32'h100, 2'd3);
    csr_op(`CSR_PMPADDR0, 32'h40, 2'd3);
    // Entry 1 locked TOR with read only
    csr_op(`CSR_PMPCFG0, 32'h0000_8900, 2'd3);
    csr_op(`CSR_PMPADDR0 + 12'd1, 32'h200, 2'd3);
    csr_op(`CSR_PMPADDR0, 32'h55, 2'd3);
    csr_op(`CSR_PMPCFG0, 32'd0, 2'd3);
    csr_op(`CSR_MSECCFG, 32'h4, 2'd3);
    csr_op(`CSR_MSECCFG, 32'h0, 2'd3);
    wait_idle();
    check_value("locking rlb refused", 32'd0, last_rdata);
    csr_op(`CSR_PMPADDR0, 32'h0, 2'd3);
    wait_idle();
    check_value("locking addr0 held", 32'h40, last_rdata);
    csr_op(`CSR_PMPADDR0 + 12'd1, 32'h0, 2'd3);
    wait_idle();
    check_value("locking addr1 held", 32'h100, last_rdata);
    csr_op(`CSR_PMPCFG0, 32'd0, 2'd3);
    wait_idle();
    check_value("locking cfg held", 32'h0000_8900, last_rdata);
    apply_reset();
    csr_op(`CSR_MSECCFG, 32'h4, 2'd3);
    csr_op(`CSR_PMPCFG0, 32'h0000_8900, 2'd3);
    csr_op(`CSR_PMPADDR0 + 12'd1, 32'h200, 2'd3);
    csr_op(`CSR_PMPADDR0, 32'h55, 2'd3);
    csr_op(`CSR_PMPCFG0, 32'd0, 2'd3);
    csr_op(`CSR_PMPADDR0, 32'h0, 2'd3);
    wait_idle();
    check_value("locking bypass addr0", 32'h55, last_rdata);
    csr_op(`CSR_PMPADDR0 + 12'd1, 32'h0, 2'd3);
    csr_op(`CSR_PMPCFG0, 32'd0, 2'd3);
    wait_idle();
    check_value("locking bypass cfg", 32'd0, last_rdata);
    end_test();

    start_test("access_decisions");
    for (int round = 0; round < 30; round++) begin
      apply_reset();
      for (int i = 0; i < 4; i++) begin
        csr_op(`CSR_PMPADDR0 + 12'(i), rand_bits(12), 2'd3);
      end
      csr_op(`CSR_PMPCFG0, rand_bits(32), 2'd3);
      for (int i = 0; i < 10; i++) begin
        acc_op();
      end
    end
    end_test();

    start_test("back_pressure");
    bp_mode = 1'b1;
    for (int i = 0; i < 40; i++) begin
      csr_op(valid_csr_addr(), rand_bits(32), 2'd3);
      for (int j = 0; j < 3; j++) begin
        acc_op();
      end
    end
    end_test();
    bp_mode = 1'b0;

    $display("%0d tests run, %0d failed, %0d errors", tests, failed_tests, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

/* all.f */
+incdir+design
+incdir+testbench
design/pmp_pkg.sv
design/pmp_csr_if.sv
design/pmp_cfg_legalize.sv
design/pmp_csr_regs.sv
design/pmp_region_match.sv
design/pmp_access_check.sv
design/pmp_top.sv
testbench/pmp_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f all.f --top-module pmp_tb; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vpmp_tb)
status=$?
printf '%s\n' "$out"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "Simulation finished: PASS"; then
  exit 0
fi
exit 1
